//--- list.f
logic/rob_pkg.sv
logic/rob_ptr_ctrl.sv
logic/rob_entry_array.sv
logic/rob_retire.sv
logic/rob_src_lookup.sv
logic/rob_top.sv
verif/rob_tb.sv

//--- logic/rob_entry_array.sv
// Re-order buffer entry storage
// Fills entries on allocation, takes CDB writeback and keeps the
// per-entry ready and redirect bits

`timescale 1ns/10ps

module rob_entry_array import rob_pkg::*; #(
    parameter  int OPTN_ROB_DEPTH = 8,
    parameter  int OPTN_CDB_DEPTH = 2,
    localparam int ROB_IDX_WIDTH  = $clog2(OPTN_ROB_DEPTH)
)(
    input  logic                      clk,
    input  logic                      n_rst,

    input  logic                      i_alloc_en,
    input  logic [ROB_IDX_WIDTH-1:0]  i_tail_idx,
    input  rob_op_t                   i_enq_op,
    input  addr_t                     i_enq_pc,
    input  rdest_t                    i_enq_rdest,

    input  logic                      i_cdb_en       [0:OPTN_CDB_DEPTH-1],
    input  logic                      i_cdb_redirect [0:OPTN_CDB_DEPTH-1],
    input  data_t                     i_cdb_data     [0:OPTN_CDB_DEPTH-1],
    input  addr_t                     i_cdb_addr     [0:OPTN_CDB_DEPTH-1],
    input  logic [ROB_IDX_WIDTH-1:0]  i_cdb_tag      [0:OPTN_CDB_DEPTH-1],

    input  logic                      i_retire_go,
    input  logic [ROB_IDX_WIDTH-1:0]  i_head_idx,
    input  logic                      i_redirect,

    output logic [OPTN_ROB_DEPTH-1:0] o_entry_rdy,
    output logic [OPTN_ROB_DEPTH-1:0] o_entry_redirect,
    output rob_op_t                   o_entry_op     [0:OPTN_ROB_DEPTH-1],
    output addr_t                     o_entry_pc     [0:OPTN_ROB_DEPTH-1],
    output addr_t                     o_entry_addr   [0:OPTN_ROB_DEPTH-1],
    output data_t                     o_entry_data   [0:OPTN_ROB_DEPTH-1],
    output rdest_t                    o_entry_rdest  [0:OPTN_ROB_DEPTH-1]
);

    logic [OPTN_ROB_DEPTH-1:0] enq_sel;
    logic [OPTN_ROB_DEPTH-1:0] cdb_hit;
    logic [OPTN_ROB_DEPTH-1:0] cdb_redirect_hit;
    addr_t                     addr_next [0:OPTN_ROB_DEPTH-1];
    data_t                     data_next [0:OPTN_ROB_DEPTH-1];
    logic                      cdb_in_range [0:OPTN_CDB_DEPTH-1];

    // Per entry priority mux over the CDB ports, later ports override earlier ones
    always_comb begin
        for (int e = 0; e < OPTN_ROB_DEPTH; e++) begin
            enq_sel[e]          = i_alloc_en && (i_tail_idx == ROB_IDX_WIDTH'(e));
            cdb_hit[e]          = 1'b0;
            cdb_redirect_hit[e] = 1'b0;
            addr_next[e]        = o_entry_addr[e];
            data_next[e]        = o_entry_data[e];
            for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
                if (i_cdb_en[c] && (i_cdb_tag[c] == ROB_IDX_WIDTH'(e))) begin
                    cdb_hit[e]          = 1'b1;
                    cdb_redirect_hit[e] = i_cdb_redirect[c];
                    addr_next[e]        = i_cdb_addr[c];
                    data_next[e]        = i_cdb_data[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < OPTN_ROB_DEPTH; e++) begin
            o_entry_addr[e] <= addr_next[e];
            o_entry_data[e] <= data_next[e];
            if (enq_sel[e]) begin
                o_entry_op[e]    <= i_enq_op;
                o_entry_pc[e]    <= i_enq_pc;
                o_entry_rdest[e] <= i_enq_rdest;
            end
        end
    end

    // A new entry starts pending; the head drops its ready bit as it retires
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_entry_rdy      <= '0;
            o_entry_redirect <= '0;
        end else begin
            for (int e = 0; e < OPTN_ROB_DEPTH; e++) begin
                o_entry_rdy[e] <= ~(i_redirect | enq_sel[e]
                                    | (i_retire_go && (i_head_idx == ROB_IDX_WIDTH'(e))))
                                  & (o_entry_rdy[e] | cdb_hit[e]);
                o_entry_redirect[e] <= ~enq_sel[e] & (o_entry_redirect[e] | cdb_redirect_hit[e]);
            end
        end
    end

    // Offset from the head must fall short of the tail's offset
    always_comb begin
        for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
            cdb_in_range[c] = (i_tail_idx == i_head_idx)
                || (ROB_IDX_WIDTH'(i_cdb_tag[c] - i_head_idx)
                    < ROB_IDX_WIDTH'(i_tail_idx - i_head_idx));
        end
    end

    // Execution units only complete entries that are allocated and still pending
    for (genvar c = 0; c < OPTN_CDB_DEPTH; c++) begin : g_cdb_chk
        a_cdb_pending: assert property (@(posedge clk) disable iff (!n_rst || i_redirect)
            i_cdb_en[c] |-> (cdb_in_range[c] && !o_entry_rdy[i_cdb_tag[c]]));
    end

endmodule

//--- logic/rob_pkg.sv
// Re-order buffer shared definitions
// Widths and op classes used by every block of the buffer

package rob_pkg;

    // Register data value written back on the CDB and retired to the register map
    typedef logic [31:0] data_t;

    // Instruction pc or branch target address
    typedef logic [31:0] addr_t;

    // Architectural destination register index
    typedef logic [4:0] rdest_t;

    // Op class kept per entry
    // A branch redirects to its target, anything else back to its own pc
    typedef enum logic [0:0] {
        ROB_OP_INT = 1'b0,
        ROB_OP_BR  = 1'b1
    } rob_op_t;

    // Source operands looked up for each dispatched instruction
    localparam int NUM_SRC = 2;

endpackage

//--- logic/rob_ptr_ctrl.sv
// Re-order buffer pointer control
// Head and tail pointers with a wrap bit, registered full and empty flags,
// allocation accept and pointer flush on a redirect

`timescale 1ns/10ps

module rob_ptr_ctrl #(
    parameter  int OPTN_ROB_DEPTH = 8,
    localparam int ROB_IDX_WIDTH  = $clog2(OPTN_ROB_DEPTH)
)(
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic                     i_enq_en,
    input  logic                     i_retire_go,
    input  logic                     i_redirect,

    output logic                     o_alloc_en,
    output logic [ROB_IDX_WIDTH-1:0] o_head_idx,
    output logic [ROB_IDX_WIDTH-1:0] o_tail_idx,
    output logic                     o_full,
    output logic                     o_empty
);

    // The extra top bit tells a full buffer apart from an empty one
    logic [ROB_IDX_WIDTH:0] head_q;
    logic [ROB_IDX_WIDTH:0] tail_q;
    logic [ROB_IDX_WIDTH:0] head_next;
    logic [ROB_IDX_WIDTH:0] tail_next;

    assign o_alloc_en = i_enq_en & ~o_full;
    assign o_head_idx = head_q[ROB_IDX_WIDTH-1:0];
    assign o_tail_idx = tail_q[ROB_IDX_WIDTH-1:0];

    // A flush wins over a same-cycle allocation or retirement
    assign head_next = i_redirect ? '0 : (i_retire_go ? head_q + 1'b1 : head_q);
    assign tail_next = i_redirect ? '0 : (o_alloc_en ? tail_q + 1'b1 : tail_q);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
        end
    end

    // Flags come from the next pointers so they line up with the new state
    always_ff @(posedge clk) begin
        if (!n_rst || i_redirect) begin
            o_full  <= 1'b0;
            o_empty <= 1'b1;
        end else begin
            o_full  <= ({~tail_next[ROB_IDX_WIDTH], tail_next[ROB_IDX_WIDTH-1:0]} == head_next);
            o_empty <= (tail_next == head_next);
        end
    end

    // Occupancy never exceeds the depth, so nothing was accepted while full
    a_no_overfill: assert property (@(posedge clk) disable iff (!n_rst)
        (tail_q - head_q) <= (ROB_IDX_WIDTH+1)'(OPTN_ROB_DEPTH));

    // The retire stage never pops an empty buffer
    a_no_retire_empty: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_retire_go && (head_q == tail_q)));

endmodule

//--- logic/rob_retire.sv
// Re-order buffer retirement
// Retires the ready head entry in order to the register map and
// raises the fetch redirect when that entry is flagged

`timescale 1ns/10ps

module rob_retire import rob_pkg::*; #(
    parameter  int OPTN_ROB_DEPTH = 8,
    localparam int ROB_IDX_WIDTH  = $clog2(OPTN_ROB_DEPTH)
)(
    input  logic                      clk,
    input  logic                      n_rst,

    input  logic [ROB_IDX_WIDTH-1:0]  i_head_idx,
    input  logic                      i_empty,
    input  logic [OPTN_ROB_DEPTH-1:0] i_entry_rdy,
    input  logic [OPTN_ROB_DEPTH-1:0] i_entry_redirect,
    input  rob_op_t                   i_entry_op    [0:OPTN_ROB_DEPTH-1],
    input  addr_t                     i_entry_pc    [0:OPTN_ROB_DEPTH-1],
    input  addr_t                     i_entry_addr  [0:OPTN_ROB_DEPTH-1],
    input  data_t                     i_entry_data  [0:OPTN_ROB_DEPTH-1],
    input  rdest_t                    i_entry_rdest [0:OPTN_ROB_DEPTH-1],

    output logic                      o_retire_go,
    output logic                      o_retire_en,
    output data_t                     o_retire_data,
    output rdest_t                    o_retire_rdest,
    output logic [ROB_IDX_WIDTH-1:0]  o_retire_tag,
    output logic                      o_redirect,
    output addr_t                     o_redirect_addr
);

    // Nothing retires in the flush cycle, younger entries are being discarded
    assign o_retire_go = ~i_empty & i_entry_rdy[i_head_idx] & ~o_redirect;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_retire_en <= 1'b0;
            o_redirect  <= 1'b0;
        end else begin
            o_retire_en <= o_retire_go;
            o_redirect  <= o_retire_go & i_entry_redirect[i_head_idx];
        end
    end

    always_ff @(posedge clk) begin
        o_retire_data  <= i_entry_data[i_head_idx];
        o_retire_rdest <= i_entry_rdest[i_head_idx];
        o_retire_tag   <= i_head_idx;
        // Mispredicted branches resume at the target, exceptions replay the pc
        o_redirect_addr <= (i_entry_op[i_head_idx] == ROB_OP_BR) ? i_entry_addr[i_head_idx]
                                                                   : i_entry_pc[i_head_idx];
    end

    // The flush empties the buffer, so a second redirect cannot follow directly
    a_redirect_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        o_redirect |=> (!o_redirect && i_empty));

endmodule

//--- logic/rob_src_lookup.sv
// Re-order buffer source operand lookup
// Picks data, tag and ready for each source of the dispatched instruction
// from the register map, the entry array or a same-cycle CDB bypass

`timescale 1ns/10ps

module rob_src_lookup import rob_pkg::*; #(
    parameter  int OPTN_ROB_DEPTH = 8,
    parameter  int OPTN_CDB_DEPTH = 2,
    localparam int ROB_IDX_WIDTH  = $clog2(OPTN_ROB_DEPTH)
)(
    input  logic                      clk,
    input  logic                      i_rs_stall,

    input  data_t                     i_lookup_data     [0:NUM_SRC-1],
    input  logic [ROB_IDX_WIDTH-1:0]  i_lookup_tag      [0:NUM_SRC-1],
    input  logic                      i_lookup_rdy      [0:NUM_SRC-1],
    input  logic                      i_lookup_rdy_ovrd [0:NUM_SRC-1],

    input  logic                      i_cdb_en          [0:OPTN_CDB_DEPTH-1],
    input  data_t                     i_cdb_data        [0:OPTN_CDB_DEPTH-1],
    input  logic [ROB_IDX_WIDTH-1:0]  i_cdb_tag         [0:OPTN_CDB_DEPTH-1],

    input  logic [OPTN_ROB_DEPTH-1:0] i_entry_rdy,
    input  data_t                     i_entry_data      [0:OPTN_ROB_DEPTH-1],

    output data_t                     o_src_data        [0:NUM_SRC-1],
    output logic [ROB_IDX_WIDTH-1:0]  o_src_tag         [0:NUM_SRC-1],
    output logic                      o_src_rdy         [0:NUM_SRC-1]
);

    logic                     map_rdy  [0:NUM_SRC-1];
    data_t                    src_data [0:NUM_SRC-1];
    logic [ROB_IDX_WIDTH-1:0] src_tag  [0:NUM_SRC-1];
    logic                     src_rdy  [0:NUM_SRC-1];

    // The override marks a source the instruction does not use as ready
    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            map_rdy[s]  = i_lookup_rdy[s] | i_lookup_rdy_ovrd[s];
            src_rdy[s]  = map_rdy[s] | i_entry_rdy[i_lookup_tag[s]];
            src_data[s] = i_entry_data[i_lookup_tag[s]];
            src_tag[s]  = i_lookup_tag[s];

            // A broadcast this cycle is newer than what the entry holds
            for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
                if (i_cdb_en[c] && (i_cdb_tag[c] == i_lookup_tag[s])) begin
                    src_rdy[s]  = 1'b1;
                    src_data[s] = i_cdb_data[c];
                end
            end

            if (map_rdy[s]) begin
                src_data[s] = i_lookup_data[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rs_stall) begin
            o_src_data <= src_data;
            o_src_tag  <= src_tag;
            o_src_rdy  <= src_rdy;
        end
    end

endmodule

//--- logic/rob_top.sv
// Re-order buffer top level
// Connects pointer control, entry storage, retirement and source lookup

`timescale 1ns/10ps

module rob_top import rob_pkg::*; #(
    parameter  int OPTN_ROB_DEPTH = 8,
    parameter  int OPTN_CDB_DEPTH = 2,
    localparam int ROB_IDX_WIDTH  = $clog2(OPTN_ROB_DEPTH)
)(
    input  logic                     clk,
    input  logic                     n_rst,

    // Dispatch
    input  logic                     i_enq_en,
    input  rob_op_t                  i_enq_op,
    input  addr_t                    i_enq_pc,
    input  rdest_t                   i_enq_rdest,
    output logic [ROB_IDX_WIDTH-1:0] o_enq_tag,
    output logic                     o_rob_stall,

    // Common data bus
    input  logic                     i_cdb_en          [0:OPTN_CDB_DEPTH-1],
    input  logic                     i_cdb_redirect    [0:OPTN_CDB_DEPTH-1],
    input  data_t                    i_cdb_data        [0:OPTN_CDB_DEPTH-1],
    input  addr_t                    i_cdb_addr        [0:OPTN_CDB_DEPTH-1],
    input  logic [ROB_IDX_WIDTH-1:0] i_cdb_tag         [0:OPTN_CDB_DEPTH-1],

    // Source operands toward the reservation stations
    input  data_t                    i_lookup_data     [0:NUM_SRC-1],
    input  logic [ROB_IDX_WIDTH-1:0] i_lookup_tag      [0:NUM_SRC-1],
    input  logic                     i_lookup_rdy      [0:NUM_SRC-1],
    input  logic                     i_lookup_rdy_ovrd [0:NUM_SRC-1],
    input  logic                     i_rs_stall,
    output data_t                    o_src_data        [0:NUM_SRC-1],
    output logic [ROB_IDX_WIDTH-1:0] o_src_tag         [0:NUM_SRC-1],
    output logic                     o_src_rdy         [0:NUM_SRC-1],

    // Register map update and fetch redirect
    output logic                     o_retire_en,
    output data_t                    o_retire_data,
    output rdest_t                   o_retire_rdest,
    output logic [ROB_IDX_WIDTH-1:0] o_retire_tag,
    output logic                     o_redirect,
    output addr_t                    o_redirect_addr
);

    logic [ROB_IDX_WIDTH-1:0]  head_idx;
    logic [ROB_IDX_WIDTH-1:0]  tail_idx;
    logic                      empty;
    logic                      alloc_en;
    logic                      retire_go;
    logic [OPTN_ROB_DEPTH-1:0] entry_rdy;
    logic [OPTN_ROB_DEPTH-1:0] entry_redirect;
    rob_op_t                   entry_op    [0:OPTN_ROB_DEPTH-1];
    addr_t                     entry_pc    [0:OPTN_ROB_DEPTH-1];
    addr_t                     entry_addr  [0:OPTN_ROB_DEPTH-1];
    data_t                     entry_data  [0:OPTN_ROB_DEPTH-1];
    rdest_t                    entry_rdest [0:OPTN_ROB_DEPTH-1];

    // The rename tag is the slot the next allocation lands in
    assign o_enq_tag = tail_idx;

    rob_ptr_ctrl #(
        .OPTN_ROB_DEPTH (OPTN_ROB_DEPTH)
    ) rob_ptr_ctrl_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_enq_en    (i_enq_en),
        .i_retire_go (retire_go),
        .i_redirect  (o_redirect),
        .o_alloc_en  (alloc_en),
        .o_head_idx  (head_idx),
        .o_tail_idx  (tail_idx),
        .o_full      (o_rob_stall),
        .o_empty     (empty)
    );

    rob_entry_array #(
        .OPTN_ROB_DEPTH (OPTN_ROB_DEPTH),
        .OPTN_CDB_DEPTH (OPTN_CDB_DEPTH)
    ) rob_entry_array_inst (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_alloc_en       (alloc_en),
        .i_tail_idx       (tail_idx),
        .i_enq_op         (i_enq_op),
        .i_enq_pc         (i_enq_pc),
        .i_enq_rdest      (i_enq_rdest),
        .i_cdb_en         (i_cdb_en),
        .i_cdb_redirect   (i_cdb_redirect),
        .i_cdb_data       (i_cdb_data),
        .i_cdb_addr       (i_cdb_addr),
        .i_cdb_tag        (i_cdb_tag),
        .i_retire_go      (retire_go),
        .i_head_idx       (head_idx),
        .i_redirect       (o_redirect),
        .o_entry_rdy      (entry_rdy),
        .o_entry_redirect (entry_redirect),
        .o_entry_op       (entry_op),
        .o_entry_pc       (entry_pc),
        .o_entry_addr     (entry_addr),
        .o_entry_data     (entry_data),
        .o_entry_rdest    (entry_rdest)
    );

    rob_retire #(
        .OPTN_ROB_DEPTH (OPTN_ROB_DEPTH)
    ) rob_retire_inst (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_head_idx       (head_idx),
        .i_empty          (empty),
        .i_entry_rdy      (entry_rdy),
        .i_entry_redirect (entry_redirect),
        .i_entry_op       (entry_op),
        .i_entry_pc       (entry_pc),
        .i_entry_addr     (entry_addr),
        .i_entry_data     (entry_data),
        .i_entry_rdest    (entry_rdest),
        .o_retire_go      (retire_go),
        .o_retire_en      (o_retire_en),
        .o_retire_data    (o_retire_data),
        .o_retire_rdest   (o_retire_rdest),
        .o_retire_tag     (o_retire_tag),
        .o_redirect       (o_redirect),
        .o_redirect_addr  (o_redirect_addr)
    );

    rob_src_lookup #(
        .OPTN_ROB_DEPTH (OPTN_ROB_DEPTH),
        .OPTN_CDB_DEPTH (OPTN_CDB_DEPTH)
    ) rob_src_lookup_inst (
        .clk               (clk),
        .i_rs_stall        (i_rs_stall),
        .i_lookup_data     (i_lookup_data),
        .i_lookup_tag      (i_lookup_tag),
        .i_lookup_rdy      (i_lookup_rdy),
        .i_lookup_rdy_ovrd (i_lookup_rdy_ovrd),
        .i_cdb_en          (i_cdb_en),
        .i_cdb_data        (i_cdb_data),
        .i_cdb_tag         (i_cdb_tag),
        .i_entry_rdy       (entry_rdy),
        .i_entry_data      (entry_data),
        .o_src_data        (o_src_data),
        .o_src_tag         (o_src_tag),
        .o_src_rdy         (o_src_rdy)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the re-order buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module rob_tb -f list.f -o Vrob_tb
./obj_dir/Vrob_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Finished with no errors" sim.log
echo "Simulation passed"

//--- verif/rob_tb.sv
// Re-order buffer testbench
// Drives dispatch, CDB and source lookups, and checks retirement,
// redirect and lookup results against a queue model of the buffer

`timescale 1ns/10ps

module rob_tb import rob_pkg::*;;

    localparam int DEPTH = 8;
    localparam int CDBS  = 2;
    localparam int TAG_W = $clog2(DEPTH);
    // Rough cycle lengths of the five tests
    localparam int TEST_CYCLES = 10 + 60 + 80 + 50 + 40;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

    typedef logic [TAG_W-1:0] tag_t;

    logic   clk;
    logic   n_rst;
    logic   i_enq_en;
    rob_op_t i_enq_op;
    addr_t  i_enq_pc;
    rdest_t i_enq_rdest;
    tag_t   o_enq_tag;
    logic   o_rob_stall;
    logic   i_cdb_en [0:CDBS-1];
    logic   i_cdb_redirect [0:CDBS-1];
    data_t  i_cdb_data [0:CDBS-1];
    addr_t  i_cdb_addr [0:CDBS-1];
    tag_t   i_cdb_tag [0:CDBS-1];
    data_t  i_lookup_data [0:NUM_SRC-1];
    tag_t   i_lookup_tag [0:NUM_SRC-1];
    logic   i_lookup_rdy [0:NUM_SRC-1];
    logic   i_lookup_rdy_ovrd [0:NUM_SRC-1];
    logic   i_rs_stall;
    data_t  o_src_data [0:NUM_SRC-1];
    tag_t   o_src_tag [0:NUM_SRC-1];
    logic   o_src_rdy [0:NUM_SRC-1];
    logic   o_retire_en;
    data_t  o_retire_data;
    rdest_t o_retire_rdest;
    tag_t   o_retire_tag;
    logic   o_redirect;
    addr_t  o_redirect_addr;

    // Model of allocated entries, oldest first
    tag_t    q_tag[$];
    rob_op_t q_op[$];
    addr_t   q_pc[$];
    rdest_t  q_rdest[$];
    logic    q_done[$];
    data_t   q_data[$];
    addr_t   q_addr[$];
    logic    q_redir[$];

    tag_t   exp_tail;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    integer seed;

    rob_top #(
        .OPTN_ROB_DEPTH (DEPTH),
        .OPTN_CDB_DEPTH (CDBS)
    ) rob_top_inst (
        .clk (clk), .n_rst (n_rst),
        .i_enq_en (i_enq_en), .i_enq_op (i_enq_op), .i_enq_pc (i_enq_pc),
        .i_enq_rdest (i_enq_rdest), .o_enq_tag (o_enq_tag), .o_rob_stall (o_rob_stall),
        .i_cdb_en (i_cdb_en), .i_cdb_redirect (i_cdb_redirect), .i_cdb_data (i_cdb_data),
        .i_cdb_addr (i_cdb_addr), .i_cdb_tag (i_cdb_tag),
        .i_lookup_data (i_lookup_data), .i_lookup_tag (i_lookup_tag),
        .i_lookup_rdy (i_lookup_rdy), .i_lookup_rdy_ovrd (i_lookup_rdy_ovrd),
        .i_rs_stall (i_rs_stall), .o_src_data (o_src_data), .o_src_tag (o_src_tag),
        .o_src_rdy (o_src_rdy), .o_retire_en (o_retire_en), .o_retire_data (o_retire_data),
        .o_retire_rdest (o_retire_rdest), .o_retire_tag (o_retire_tag),
        .o_redirect (o_redirect), .o_redirect_addr (o_redirect_addr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rdest(input string name, input rdest_t got, input rdest_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // A branch resumes at its CDB target, anything else replays its own pc
    function automatic addr_t redirect_target();
        return (q_op[0] == ROB_OP_BR) ? q_addr[0] : q_pc[0];
    endfunction

    // Expected source result from register map, override, entry and CDB bypass
    function automatic void src_ref(input logic rdy, input logic ovrd, input data_t map_data,
                                    input logic e_rdy, input data_t e_data, input logic hit,
                                    input data_t hit_data, output data_t d, output logic r);
        r = rdy | ovrd | e_rdy | hit;
        d = (rdy | ovrd) ? map_data : (hit ? hit_data : e_data);
    endfunction

    // Retirement and redirect monitor
    always @(negedge clk) begin
        if (n_rst && o_retire_en) begin
            if (q_tag.size() == 0) begin
                $display("An entry retired while none was expected to retire");
                errors++;
            end else begin
                if (!q_done[0]) begin
                    $display("Entry %0d retired before it was completed", q_tag[0]);
                    errors++;
                end
                check_tag("o_retire_tag", o_retire_tag, q_tag[0]);
                check_data("o_retire_data", o_retire_data, q_data[0]);
                check_rdest("o_retire_rdest", o_retire_rdest, q_rdest[0]);
                check_bit("o_redirect", o_redirect, q_redir[0]);
                if (q_redir[0]) begin
                    check_addr("o_redirect_addr", o_redirect_addr, redirect_target());
                    q_tag.delete();
                    q_op.delete();
                    q_pc.delete();
                    q_rdest.delete();
                    q_done.delete();
                    q_data.delete();
                    q_addr.delete();
                    q_redir.delete();
                    exp_tail = '0;
                end else begin
                    void'(q_tag.pop_front());
                    void'(q_op.pop_front());
                    void'(q_pc.pop_front());
                    void'(q_rdest.pop_front());
                    void'(q_done.pop_front());
                    void'(q_data.pop_front());
                    void'(q_addr.pop_front());
                    void'(q_redir.pop_front());
                end
            end
        end else if (n_rst && o_redirect) begin
            $display("Redirect was raised without a retirement");
            errors++;
        end
    end

    task automatic drive_alloc(input rob_op_t op, input addr_t pc, input rdest_t rdest);
        @(negedge clk);
        while (o_rob_stall) begin
            @(negedge clk);
        end
        check_tag("o_enq_tag", o_enq_tag, exp_tail);
        i_enq_en = 1'b1;
        i_enq_op = op;
        i_enq_pc = pc;
        i_enq_rdest = rdest;
        q_tag.push_back(exp_tail);
        q_op.push_back(op);
        q_pc.push_back(pc);
        q_rdest.push_back(rdest);
        q_done.push_back(1'b0);
        q_data.push_back('0);
        q_addr.push_back('0);
        q_redir.push_back(1'b0);
        exp_tail++;
        @(negedge clk);
        i_enq_en = 1'b0;
    endtask

    // Puts one broadcast on a port and marks the entry complete in the model
    task automatic set_cdb(input int port, input tag_t tag, input data_t data, input addr_t addr,
                           input logic redir);
        i_cdb_en[port] = 1'b1;
        i_cdb_tag[port] = tag;
        i_cdb_data[port] = data;
        i_cdb_addr[port] = addr;
        i_cdb_redirect[port] = redir;
        foreach (q_tag[i]) begin
            if (q_tag[i] == tag) begin
                q_done[i] = 1'b1;
                q_data[i] = data;
                q_addr[i] = addr;
                q_redir[i] = redir;
            end
        end
    endtask

    task automatic clear_cdb();
        for (int c = 0; c < CDBS; c++) begin
            i_cdb_en[c] = 1'b0;
            i_cdb_redirect[c] = 1'b0;
        end
    endtask

    task automatic broadcast(input tag_t tag, input data_t data, input addr_t addr,
                             input logic redir);
        @(negedge clk);
        set_cdb(0, tag, data, addr, redir);
        @(negedge clk);
        clear_cdb();
    endtask

    task automatic wait_queue_len(input int len);
        while (q_tag.size() > len) begin
            @(posedge clk);
        end
    endtask

    task automatic lookup_case(input logic rdy, input logic ovrd, input data_t map_data,
                               input tag_t tag, input logic hit, input data_t hit_data,
                               input logic e_rdy, input data_t e_data);
        data_t exp_d;
        logic  exp_r;
        @(negedge clk);
        for (int s = 0; s < NUM_SRC; s++) begin
            i_lookup_rdy[s] = rdy;
            i_lookup_rdy_ovrd[s] = ovrd;
            i_lookup_data[s] = map_data + data_t'(s);
            i_lookup_tag[s] = tag;
        end
        if (hit) begin
            set_cdb(1, tag, hit_data, '0, 1'b0);
        end
        @(negedge clk);
        clear_cdb();
        for (int s = 0; s < NUM_SRC; s++) begin
            src_ref(rdy, ovrd, map_data + data_t'(s), e_rdy, e_data, hit, hit_data,
                    exp_d, exp_r);
            check_data("o_src_data", o_src_data[s], exp_d);
            check_bit("o_src_rdy", o_src_rdy[s], exp_r);
            check_tag("o_src_tag", o_src_tag[s], tag);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("Test %0s: FAIL", name);
        end else begin
            $display("Test %0s: PASS", name);
        end
    endtask

    initial begin
        int    e0;
        tag_t  perm [0:DEPTH-1];
        tag_t  t;
        int    j;

        clk = 1'b0;
        n_rst = 1'b0;
        i_enq_en = 1'b0;
        i_enq_op = ROB_OP_INT;
        i_enq_pc = '0;
        i_enq_rdest = '0;
        i_rs_stall = 1'b0;
        for (int c = 0; c < CDBS; c++) begin
            i_cdb_en[c] = 1'b0;
            i_cdb_redirect[c] = 1'b0;
            i_cdb_data[c] = '0;
            i_cdb_addr[c] = '0;
            i_cdb_tag[c] = '0;
        end
        for (int s = 0; s < NUM_SRC; s++) begin
            i_lookup_data[s] = '0;
            i_lookup_tag[s] = '0;
            i_lookup_rdy[s] = 1'b0;
            i_lookup_rdy_ovrd[s] = 1'b0;
        end
        exp_tail = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        seed = 32'hffc7;

        repeat (4) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        e0 = errors;
        @(negedge clk);
        check_bit("o_retire_en", o_retire_en, 1'b0);
        check_bit("o_redirect", o_redirect, 1'b0);
        check_bit("o_rob_stall", o_rob_stall, 1'b0);
        report_test("reset", e0);

        // Fill the buffer, then complete it in shuffled pairs on both ports
        e0 = errors;
        for (int i = 0; i < DEPTH; i++) begin
            drive_alloc(ROB_OP_INT, addr_t'(32'h1000 + 4 * i), rdest_t'(i + 3));
            perm[i] = tag_t'(i);
        end
        for (int i = DEPTH - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            t = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
        for (int i = 0; i < DEPTH; i += 2) begin
            @(negedge clk);
            set_cdb(0, perm[i], $random(seed), '0, 1'b0);
            set_cdb(1, perm[i + 1], $random(seed), '0, 1'b0);
            @(negedge clk);
            clear_cdb();
        end
        wait_queue_len(0);
        report_test("in-order retirement", e0);

        // Full buffer ignores dispatch until the head retires
        e0 = errors;
        for (int i = 0; i < DEPTH; i++) begin
            drive_alloc(ROB_OP_INT, addr_t'(32'h2000 + 4 * i), rdest_t'(i + 10));
        end
        check_bit("o_rob_stall", o_rob_stall, 1'b1);
        i_enq_en = 1'b1;
        repeat (2) @(negedge clk);
        i_enq_en = 1'b0;
        check_bit("o_rob_stall", o_rob_stall, 1'b1);
        check_tag("o_enq_tag", o_enq_tag, tag_t'(0));
        broadcast(tag_t'(0), 32'h0a0a0a0a, '0, 1'b0);
        wait_queue_len(DEPTH - 1);
        drive_alloc(ROB_OP_INT, 32'h2100, 5'd20);
        for (int i = 1; i <= DEPTH; i++) begin
            broadcast(tag_t'(i % DEPTH), data_t'(32'h300 + i), '0, 1'b0);
        end
        wait_queue_len(0);
        report_test("full and wrap", e0);

        // Mispredicted branch behind younger completed entries, then an exception
        e0 = errors;
        drive_alloc(ROB_OP_BR, 32'h0100, 5'd1);
        drive_alloc(ROB_OP_INT, 32'h0104, 5'd2);
        drive_alloc(ROB_OP_INT, 32'h0108, 5'd3);
        t = q_tag[0];
        broadcast(t + 2'd2, 32'h22, '0, 1'b0);
        broadcast(t + 2'd1, 32'h11, '0, 1'b0);
        broadcast(t, 32'hbb, 32'h8000, 1'b1);
        wait_queue_len(0);
        drive_alloc(ROB_OP_INT, 32'h0200, 5'd4);
        broadcast(tag_t'(0), 32'h44, 32'h9999, 1'b1);
        wait_queue_len(0);
        report_test("redirect", e0);

        // Source lookups with tag 0 pending and tag 1 completed
        e0 = errors;
        drive_alloc(ROB_OP_INT, 32'h0300, 5'd5);
        drive_alloc(ROB_OP_INT, 32'h0304, 5'd6);
        broadcast(tag_t'(1), 32'hd1d1d1d1, '0, 1'b0);
        lookup_case(1'b1, 1'b0, 32'h11110000, tag_t'(0), 1'b0, '0, 1'b0, '0);
        lookup_case(1'b0, 1'b1, 32'h22220000, tag_t'(0), 1'b0, '0, 1'b0, '0);
        lookup_case(1'b0, 1'b0, 32'h33330000, tag_t'(1), 1'b0, '0, 1'b1, 32'hd1d1d1d1);
        lookup_case(1'b0, 1'b0, 32'h44440000, tag_t'(0), 1'b1, 32'hc0dec0de, 1'b0, '0);
        // The bypass result above must hold while the stations stall
        i_rs_stall = 1'b1;
        for (int s = 0; s < NUM_SRC; s++) begin
            i_lookup_rdy[s] = 1'b1;
            i_lookup_data[s] = 32'hdeadbeef;
            i_lookup_tag[s] = tag_t'(1);
        end
        repeat (2) @(negedge clk);
        for (int s = 0; s < NUM_SRC; s++) begin
            check_data("o_src_data", o_src_data[s], 32'hc0dec0de);
            check_bit("o_src_rdy", o_src_rdy[s], 1'b1);
            check_tag("o_src_tag", o_src_tag[s], tag_t'(0));
        end
        i_rs_stall = 1'b0;
        wait_queue_len(0);
        report_test("source lookup", e0);

        repeat (3) @(negedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
